/* include/cmd_defs.svh */
`ifndef CMD_DEFS_SVH
`define CMD_DEFS_SVH

// link word and command field
`define CMD_DATA_W 32
`define CMD_CODE_W 5              // code sits in bits 4..0 of the command word

// command codes, anything else is unknown
`define CC_LOOPBACK 5'd1
`define CC_RD_REG   5'd2
`define CC_WR_REG   5'd3

// register numbers
`define REG_BUFFER_SIZE      32'd0    // read/write
`define REG_CHANNEL_NUM      32'd1
`define REG_POST_TRIG_SIZE   32'd2
`define REG_INITIAL_TRIG_NUM 32'd3    // writing pulses trig_num_we
`define REG_DATA_DELAY       32'd4
`define REG_CUR_TRIG_NUM     32'd5    // read only
`define REG_CUR_DATA_DELAY   32'd6    // read only
`define REG_COUNT            32'd7    // at or above is illegal

`endif

/* src/cmd_pkg.sv */
`include "cmd_defs.svh"

package cmd_pkg;

	//////////////////////////////
	// link types

	typedef logic [`CMD_DATA_W-1:0] word_t; // one word on either stream

	// known command codes, decoded from bits 4..0 of word 1
	typedef enum logic [`CMD_CODE_W-1:0] {
		CMD_LOOPBACK = `CC_LOOPBACK,
		CMD_RD_REG   = `CC_RD_REG,
		CMD_WR_REG   = `CC_WR_REG
	} cmd_code_t;

	// kept full width so an out of range number is never aliased
	typedef logic [`CMD_DATA_W-1:0] reg_num_t;

	//////////////////////////////
	// transmit word sources

	typedef enum logic [2:0] {
		SEL_SERIAL,      // echoed serial number
		SEL_COMMAND,     // echoed command word
		SEL_INV_COMMAND, // error reply
		SEL_RX_DATA,     // loopback payload
		SEL_REG_DATA     // register read value
	} tx_sel_t;

endpackage

/* src/tx_path_if.sv */
`timescale 1ns/1ps
`include "cmd_defs.svh"

interface tx_path_if import cmd_pkg::*; ();

	// controller -> builder
	logic capture_serial;    // rx_data is the serial number
	logic capture_command;   // rx_data is the command word
	logic load;              // load the output stage
	tx_sel_t sel;            // source for the loaded word
	logic last;              // tlast for the loaded word

	// builder -> controller
	logic full;              // output stage holds a word not yet taken
	logic [`CMD_CODE_W-1:0] code; // captured command code

	modport ctrl (
		output capture_serial, capture_command, load, sel, last,
		input full, code
	);

	modport builder (
		input capture_serial, capture_command, load, sel, last,
		output full, code
	);

endinterface

/* src/cmd_frame_ctrl.sv */
`timescale 1ns/1ps
`include "cmd_defs.svh"

module cmd_frame_ctrl import cmd_pkg::*; (
	input logic clk,
	input logic reset,
	// receive stream control
	input logic rx_tvalid,
	input logic rx_tlast,
	output logic rx_tready,
	// transmit builder
	tx_path_if.ctrl tx,
	input logic tx_tready,
	// register bank
	output logic reg_num_le,
	output logic reg_wr_en,
	input logic reg_illegal
);

	typedef enum logic [3:0] {
		S_START,     // one idle cycle out of reset
		S_IDLE,      // wait for word 0
		S_CMD,       // wait for word 1
		S_DECODE,    // code is captured, pick a path
		S_DRAIN,     // skip words up to rx_tlast
		S_SERIAL,    // send serial number
		S_COMMAND,   // send command word
		S_LOOP,      // echo payload
		S_REG_NUM,   // take register number
		S_REG_DATA,  // take write data
		S_FINAL,     // send closing word of rd/wr/unknown
		S_DONE       // wait for last word to leave
	} state_t;

	typedef enum logic [1:0] {
		PATH_LOOP,
		PATH_RD,
		PATH_WR,
		PATH_UNK
	} path_t;

	state_t state, next_state;
	path_t path;           // path of the frame in progress
	logic frame_end;       // latest accepted word carried tlast
	logic rx_hs;
	logic can_load;        // output stage free now or freed this edge

	function automatic path_t decode_path(input logic [`CMD_CODE_W-1:0] code);
		case (code)
			CMD_LOOPBACK: decode_path = PATH_LOOP;
			CMD_RD_REG:   decode_path = PATH_RD;
			CMD_WR_REG:   decode_path = PATH_WR;
			default:      decode_path = PATH_UNK;
		endcase
	endfunction

	assign rx_hs = rx_tvalid && rx_tready;
	assign can_load = !tx.full || tx_tready;

	//////////////////////////////
	// state and frame tracking

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_START;
			path <= PATH_UNK;
			frame_end <= 1'b0;
		end else begin
			state <= next_state;
			if (state == S_DECODE)
				path <= decode_path(tx.code); // held for the rest of the frame
			if (rx_hs)
				frame_end <= rx_tlast;
		end
	end

	//////////////////////////////
	// next state and strobes

	always_comb begin
		next_state = state;
		rx_tready = 1'b0;
		tx.capture_serial = 1'b0;
		tx.capture_command = 1'b0;
		tx.load = 1'b0;
		tx.sel = SEL_SERIAL;
		tx.last = 1'b0;
		reg_num_le = 1'b0;
		reg_wr_en = 1'b0;
		case (state)
			S_START: next_state = S_IDLE;
			S_IDLE: begin
				rx_tready = 1'b1;
				tx.capture_serial = rx_tvalid;
				if (rx_tvalid)
					next_state = S_CMD;
			end
			S_CMD: begin
				rx_tready = 1'b1;
				tx.capture_command = rx_tvalid;
				if (rx_tvalid)
					next_state = S_DECODE;
			end
			S_DECODE: begin
				// unknown command drains the frame before replying
				if (decode_path(tx.code) == PATH_UNK && !frame_end)
					next_state = S_DRAIN;
				else
					next_state = S_SERIAL;
			end
			S_DRAIN: begin
				rx_tready = 1'b1;
				if (rx_tvalid && rx_tlast)
					next_state = (path == PATH_UNK) ? S_SERIAL : S_FINAL;
			end
			S_SERIAL: begin
				if (can_load) begin
					tx.load = 1'b1;
					tx.sel = SEL_SERIAL;
					case (path)
						PATH_UNK: next_state = S_FINAL;
						PATH_WR:  next_state = S_REG_NUM; // cmd word waits for legality
						default:  next_state = S_COMMAND;
					endcase
				end
			end
			S_COMMAND: begin
				if (can_load) begin
					tx.load = 1'b1;
					tx.sel = SEL_COMMAND;
					tx.last = (path == PATH_LOOP) && frame_end; // loopback without payload
					if (path == PATH_RD)
						next_state = S_REG_NUM;
					else
						next_state = frame_end ? S_DONE : S_LOOP;
				end
			end
			S_LOOP: begin
				// one word in flight, so accept only into an empty stage
				rx_tready = !tx.full;
				if (rx_tvalid && !tx.full) begin
					tx.load = 1'b1;
					tx.sel = SEL_RX_DATA;
					tx.last = rx_tlast;
					if (rx_tlast)
						next_state = S_DONE;
				end
			end
			S_REG_NUM: begin
				rx_tready = 1'b1;
				reg_num_le = rx_tvalid;
				if (rx_tvalid) begin
					if (path == PATH_WR)
						next_state = S_REG_DATA;
					else
						next_state = rx_tlast ? S_FINAL : S_DRAIN;
				end
			end
			S_REG_DATA: begin
				rx_tready = 1'b1;
				reg_wr_en = rx_tvalid;          // bank blocks illegal writes
				if (rx_tvalid)
					next_state = rx_tlast ? S_FINAL : S_DRAIN;
			end
			S_FINAL: begin
				if (can_load) begin
					tx.load = 1'b1;
					tx.last = 1'b1;
					if (path == PATH_UNK || reg_illegal)
						tx.sel = SEL_INV_COMMAND;
					else if (path == PATH_RD)
						tx.sel = SEL_REG_DATA;
					else
						tx.sel = SEL_COMMAND;   // write acknowledge
					next_state = S_DONE;
				end
			end
			S_DONE: begin
				if (tx.full && tx_tready)
					next_state = S_IDLE;
			end
			default: next_state = S_START;
		endcase
	end

endmodule

/* src/cmd_tx_builder.sv */
`timescale 1ns/1ps
`include "cmd_defs.svh"

module cmd_tx_builder import cmd_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t rx_data,        // header words and loopback payload
	input word_t reg_rd_data,    // from the register bank
	tx_path_if.builder tx,
	// transmit stream
	output word_t tx_data,
	output logic tx_tvalid,
	output logic tx_tlast,
	input logic tx_tready
);

	word_t serial_num_reg;
	word_t command_reg;
	word_t next_word;            // mux output

	//////////////////////////////
	// header capture

	always_ff @(posedge clk) begin
		if (tx.capture_serial)
			serial_num_reg <= rx_data;
		if (tx.capture_command)
			command_reg <= rx_data;
	end

	assign tx.code = command_reg[`CMD_CODE_W-1:0]; // code field of word 1

	//////////////////////////////
	// source mux

	always_comb begin
		case (tx.sel)
			SEL_SERIAL:      next_word = serial_num_reg;
			SEL_COMMAND:     next_word = command_reg;
			SEL_INV_COMMAND: next_word = ~command_reg;   // error reply
			SEL_RX_DATA:     next_word = rx_data;
			SEL_REG_DATA:    next_word = reg_rd_data;
			default:         next_word = command_reg;
		endcase
	end

	//////////////////////////////
	// output stage

	always_ff @(posedge clk) begin
		if (tx.load)
			tx_data <= next_word;     // held until the handshake
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_tvalid <= 1'b0;
			tx_tlast <= 1'b0;
		end else if (tx.load) begin
			tx_tvalid <= 1'b1;        // reload may coincide with a take
			tx_tlast <= tx.last;
		end else if (tx_tready) begin
			tx_tvalid <= 1'b0;
		end
	end

	assign tx.full = tx_tvalid;

endmodule

/* src/cmd_reg_bank.sv */
`timescale 1ns/1ps
`include "cmd_defs.svh"

module cmd_reg_bank import cmd_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t rx_data,            // number or write data
	// controller
	input logic reg_num_le,
	input logic reg_wr_en,
	output logic reg_illegal,
	output word_t reg_rd_data,
	// acquisition settings
	output word_t buffer_size,       // words per buffer, 2 samples each
	output word_t channel_num,
	output word_t post_trig_size,    // words kept after the trigger
	output word_t initial_trig_num,
	output word_t data_delay,        // delay line tap
	output logic trig_num_we,
	// status readback
	input word_t current_trig_num,
	input word_t current_data_delay
);

	reg_num_t reg_num;               // latched register number
	logic wr_tried;                  // a write was attempted on reg_num
	logic in_range;
	logic read_only;
	logic wr_legal;

	assign in_range = reg_num < `REG_COUNT;
	assign read_only = (reg_num == `REG_CUR_TRIG_NUM) || (reg_num == `REG_CUR_DATA_DELAY);
	assign wr_legal = in_range && !read_only;

	// read only counts against a write, never against a read
	assign reg_illegal = !in_range || (wr_tried && read_only);

	assign trig_num_we = reg_wr_en && (reg_num == `REG_INITIAL_TRIG_NUM);

	//////////////////////////////
	// number latch

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_num <= '0;
			wr_tried <= 1'b0;
		end else if (reg_num_le) begin
			reg_num <= rx_data;
			wr_tried <= 1'b0;          // new access starts as a read
		end else if (reg_wr_en) begin
			wr_tried <= 1'b1;
		end
	end

	//////////////////////////////
	// settings registers

	always_ff @(posedge clk) begin
		if (reset) begin
			buffer_size <= '0;
			channel_num <= '0;
			post_trig_size <= '0;
			initial_trig_num <= '0;
			data_delay <= '0;
		end else if (reg_wr_en && wr_legal) begin
			case (reg_num)
				`REG_BUFFER_SIZE:      buffer_size <= rx_data;
				`REG_CHANNEL_NUM:      channel_num <= rx_data;
				`REG_POST_TRIG_SIZE:   post_trig_size <= rx_data;
				`REG_INITIAL_TRIG_NUM: initial_trig_num <= rx_data;
				`REG_DATA_DELAY:       data_delay <= rx_data;
				default: ;
			endcase
		end
	end

	// read decode, zero for an illegal number
	always_comb begin
		case (reg_num)
			`REG_BUFFER_SIZE:      reg_rd_data = buffer_size;
			`REG_CHANNEL_NUM:      reg_rd_data = channel_num;
			`REG_POST_TRIG_SIZE:   reg_rd_data = post_trig_size;
			`REG_INITIAL_TRIG_NUM: reg_rd_data = initial_trig_num;
			`REG_DATA_DELAY:       reg_rd_data = data_delay;
			`REG_CUR_TRIG_NUM:     reg_rd_data = current_trig_num;
			`REG_CUR_DATA_DELAY:   reg_rd_data = current_data_delay;
			default:               reg_rd_data = '0;
		endcase
	end

endmodule

/* src/command_top.sv */
`timescale 1ns/1ps
`include "cmd_defs.svh"

module command_top import cmd_pkg::*; (
	input logic clk,
	input logic reset,
	// receive stream from the master FPGA
	input word_t rx_data,
	input logic rx_tvalid,
	input logic rx_tlast,
	output logic rx_tready,
	// transmit stream to the master FPGA
	output word_t tx_data,
	output logic tx_tvalid,
	output logic tx_tlast,
	input logic tx_tready,
	// acquisition settings and status
	output word_t buffer_size,
	output word_t channel_num,
	output word_t post_trig_size,
	output word_t initial_trig_num,
	output logic trig_num_we,
	input word_t current_trig_num,
	output word_t data_delay,
	input word_t current_data_delay
);

	logic reg_num_le, reg_wr_en, reg_illegal;
	word_t reg_rd_data;

	tx_path_if tx_path ();   // controller to builder

	//////////////////////////////
	// frame parsing and reply sequencing
	cmd_frame_ctrl cmd_frame_ctrl (
		.clk(clk),
		.reset(reset),
		.rx_tvalid(rx_tvalid),
		.rx_tlast(rx_tlast),
		.rx_tready(rx_tready),
		.tx(tx_path.ctrl),
		.tx_tready(tx_tready),
		.reg_num_le(reg_num_le),
		.reg_wr_en(reg_wr_en),
		.reg_illegal(reg_illegal)
	);

	// header registers and transmit output stage
	cmd_tx_builder cmd_tx_builder (
		.clk(clk),
		.reset(reset),
		.rx_data(rx_data),
		.reg_rd_data(reg_rd_data),
		.tx(tx_path.builder),
		.tx_data(tx_data),
		.tx_tvalid(tx_tvalid),
		.tx_tlast(tx_tlast),
		.tx_tready(tx_tready)
	);

	// settings registers
	cmd_reg_bank cmd_reg_bank (
		.clk(clk),
		.reset(reset),
		.rx_data(rx_data),
		.reg_num_le(reg_num_le),
		.reg_wr_en(reg_wr_en),
		.reg_illegal(reg_illegal),
		.reg_rd_data(reg_rd_data),
		.buffer_size(buffer_size),
		.channel_num(channel_num),
		.post_trig_size(post_trig_size),
		.initial_trig_num(initial_trig_num),
		.data_delay(data_delay),
		.trig_num_we(trig_num_we),
		.current_trig_num(current_trig_num),
		.current_data_delay(current_data_delay)
	);

endmodule

/* dv/command_properties.sv */
`timescale 1ns/1ps

module command_properties import cmd_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t tx_data,
	input logic tx_tvalid,
	input logic tx_tlast,
	input logic tx_tready,
	input logic trig_num_we
);

	int violations = 0;   // count of failed assertions

	//////////////////////////////
	// transmit handshake

	// a stalled word must not change under the receiver
	tx_word_stable: assert property (@(posedge clk) disable iff (reset)
		tx_tvalid && !tx_tready |=> $stable(tx_data) && $stable(tx_tlast))
	else begin
		violations++;
		$error("tx_data or tx_tlast changed while tx_tready was low");
	end

	tx_valid_held: assert property (@(posedge clk) disable iff (reset)
		tx_tvalid && !tx_tready |=> tx_tvalid)   // no withdraw before the take
	else begin
		violations++;
		$error("tx_tvalid dropped before the handshake");
	end

	//////////////////////////////
	// trigger number strobe

	trig_we_single: assert property (@(posedge clk) disable iff (reset)
		trig_num_we |=> !trig_num_we)
	else begin
		violations++;
		$error("trig_num_we high on two cycles in a row");
	end

endmodule

bind command_top command_properties props (
	.clk(clk),
	.reset(reset),
	.tx_data(tx_data),
	.tx_tvalid(tx_tvalid),
	.tx_tlast(tx_tlast),
	.tx_tready(tx_tready),
	.trig_num_we(trig_num_we)
);

/* dv/command_tb.sv */
`timescale 1ns/1ps
`include "cmd_defs.svh"

module command_tb import cmd_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;   // cycles allowed per handshake wait
	localparam int K_LOOP = 0;
	localparam int K_READ = 1;
	localparam int K_WRITE = 2;
	localparam int K_UNKNOWN = 3;

	logic clk;
	logic reset;
	word_t rx_data;
	logic rx_tvalid;
	logic rx_tlast;
	logic rx_tready;
	word_t tx_data;
	logic tx_tvalid;
	logic tx_tlast;
	logic tx_tready;
	word_t buffer_size;
	word_t channel_num;
	word_t post_trig_size;
	word_t initial_trig_num;
	logic trig_num_we;
	word_t current_trig_num;
	word_t data_delay;
	word_t current_data_delay;

	word_t req_q[$];       // request frame with serial and command first
	word_t exp_q[$];       // expected reply words
	logic exp_last_q[$];   // expected tlast per reply word
	word_t model_regs[0:4];   // settings copy indexed by register number
	string test_name;
	int we_count;          // trig_num_we cycles in the current frame

	command_top UUT (
		.clk(clk),
		.reset(reset),
		.rx_data(rx_data),
		.rx_tvalid(rx_tvalid),
		.rx_tlast(rx_tlast),
		.rx_tready(rx_tready),
		.tx_data(tx_data),
		.tx_tvalid(tx_tvalid),
		.tx_tlast(tx_tlast),
		.tx_tready(tx_tready),
		.buffer_size(buffer_size),
		.channel_num(channel_num),
		.post_trig_size(post_trig_size),
		.initial_trig_num(initial_trig_num),
		.trig_num_we(trig_num_we),
		.current_trig_num(current_trig_num),
		.data_delay(data_delay),
		.current_data_delay(current_data_delay)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// reporting

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
			abort_run($sformatf("** Error: %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
	endtask

	//////////////////////////////
	// reference model

	task automatic push_expected(input word_t w, input logic last);
		exp_q.push_back(w);
		exp_last_q.push_back(last);
	endtask

	function automatic word_t read_reply(input word_t num, input word_t cmd);
		if (num >= `REG_COUNT)
			return ~cmd;                  // illegal number
		if (num == `REG_CUR_TRIG_NUM)
			return current_trig_num;
		if (num == `REG_CUR_DATA_DELAY)
			return current_data_delay;
		return model_regs[num[2:0]];
	endfunction

	//////////////////////////////
	// stimulus

	// builds req_q and uses num only for reads and writes
	task automatic build_frame(input int kind, input word_t num);
		logic [`CMD_CODE_W-1:0] code;
		word_t cmd;
		int len;
		case (kind)
			K_LOOP:  code = `CC_LOOPBACK;
			K_READ:  code = `CC_RD_REG;
			K_WRITE: code = `CC_WR_REG;
			default: begin
				do
					code = $urandom_range(0, 31);
				while (code inside {`CC_LOOPBACK, `CC_RD_REG, `CC_WR_REG});
			end
		endcase
		cmd = $urandom();
		cmd[`CMD_CODE_W-1:0] = code;      // upper bits stay random
		req_q.delete();
		req_q.push_back($urandom());      // serial number
		req_q.push_back(cmd);
		if (kind == K_READ) begin
			req_q.push_back(num);
		end else if (kind == K_WRITE) begin
			req_q.push_back(num);
			req_q.push_back($urandom());
		end else begin
			len = $urandom_range(1, 8);
			repeat (len) req_q.push_back($urandom());
		end
	endtask

	// one word with an optional gap in rx_tvalid before it
	task automatic send_word(input word_t data, input logic last);
		int gap;
		int waited;
		gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
		@(negedge clk);
		if (gap > 0) begin
			rx_tvalid = 1'b0;
			repeat (gap) @(negedge clk);
		end
		rx_data = data;
		rx_tlast = last;
		rx_tvalid = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!rx_tready && waited < WAIT_LIMIT);
		if (!rx_tready)
			abort_run($sformatf("%s: rx_tready never rose for a request word", test_name));
	endtask

	task automatic wait_reply();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
			abort_run($sformatf("%s: tx handshake stalled with %0d reply words missing",
				test_name, exp_q.size()));
	endtask

	// model the frame in req_q, send it and check everything it touches
	task automatic run_frame(input string name);
		word_t cmd;
		word_t num;
		int exp_we;
		int n;
		test_name = name;
		current_trig_num = $urandom();    // status inputs change between frames
		current_data_delay = $urandom();
		cmd = req_q[1];
		n = req_q.size();
		we_count = 0;
		exp_we = 0;
		push_expected(req_q[0], 1'b0);
		case (cmd[`CMD_CODE_W-1:0])
			`CC_LOOPBACK: begin
				push_expected(cmd, n == 2);
				for (int i = 2; i < n; i++)
					push_expected(req_q[i], i == n - 1);
			end
			`CC_RD_REG: begin
				push_expected(cmd, 1'b0);
				push_expected(read_reply(req_q[2], cmd), 1'b1);
			end
			`CC_WR_REG: begin
				num = req_q[2];
				if (num <= `REG_DATA_DELAY) begin   // read/write registers only
					model_regs[num[2:0]] = req_q[3];
					exp_we = (num == `REG_INITIAL_TRIG_NUM);
					push_expected(cmd, 1'b1);
				end else begin
					push_expected(~cmd, 1'b1);
				end
			end
			default: push_expected(~cmd, 1'b1);   // unknown, drained
		endcase
		for (int i = 0; i < n; i++)
			send_word(req_q[i], i == n - 1);
		@(negedge clk);
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
		wait_reply();
		check_value({name, " buffer_size"}, model_regs[`REG_BUFFER_SIZE], buffer_size);
		check_value({name, " channel_num"}, model_regs[`REG_CHANNEL_NUM], channel_num);
		check_value({name, " post_trig_size"}, model_regs[`REG_POST_TRIG_SIZE], post_trig_size);
		check_value({name, " initial_trig_num"}, model_regs[`REG_INITIAL_TRIG_NUM],
			initial_trig_num);
		check_value({name, " data_delay"}, model_regs[`REG_DATA_DELAY], data_delay);
		check_value({name, " trig_num_we cycles"}, exp_we, we_count);
	endtask

	//////////////////////////////
	// monitors

	always @(posedge clk) begin
		if (!reset && tx_tvalid && tx_tready) begin
			if (exp_q.size() == 0)
				abort_run($sformatf("%s: reply word 0x%08h sent when none was expected",
					test_name, tx_data));
			else begin
				check_value({test_name, " tx_data"}, exp_q.pop_front(), tx_data);
				check_value({test_name, " tx_tlast"}, exp_last_q.pop_front(), tx_tlast);
			end
		end
		if (!reset && trig_num_we)
			we_count++;
		check_value({test_name, " assertion failures"}, 0, UUT.props.violations);
	end

	//////////////////////////////
	// test sequence

	initial begin
		int seed_init;
		word_t num;
		seed_init = $urandom(82981);
		reset = 1'b1;
		rx_data = '0;
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
		tx_tready = 1'b0;
		current_trig_num = '0;
		current_data_delay = '0;
		test_name = "reset";
		we_count = 0;
		foreach (model_regs[i])
			model_regs[i] = '0;

		// tx_tready stalls run beside the frame sequence
		fork
			forever begin
				@(negedge clk);
				tx_tready = ($urandom_range(0, 3) != 0);   // low about a quarter of cycles
			end
		join_none

		repeat (5) @(negedge clk);
		reset = 1'b0;
		check_value("reset tx_tvalid", 0, tx_tvalid);
		check_value("reset rx_tready", 0, rx_tready);
		check_value("reset trig_num_we", 0, trig_num_we);

		for (int i = 0; i < 12; i++) begin
			build_frame(K_LOOP, '0);
			run_frame("loopback");
		end
		for (int i = 0; i < 10; i++) begin
			num = $urandom_range(0, 4);    // read/write registers
			build_frame(K_WRITE, num);
			run_frame("write");
			build_frame(K_READ, num);
			run_frame("read back");
		end
		build_frame(K_WRITE, `REG_INITIAL_TRIG_NUM);
		run_frame("trigger strobe");
		build_frame(K_READ, `REG_CUR_TRIG_NUM);
		run_frame("status read");
		build_frame(K_READ, `REG_CUR_DATA_DELAY);
		run_frame("status read");
		for (int i = 0; i < 6; i++) begin
			num = (i % 2) ? ($urandom() | 32'h10) : `REG_COUNT + $urandom_range(0, 9);
			build_frame(K_READ, num);
			run_frame("illegal read");
			num = (i % 2) ? $urandom_range(5, 6) : ($urandom() | 32'h8);  // read only or out of range
			build_frame(K_WRITE, num);
			run_frame("illegal write");
		end
		for (int i = 0; i < 6; i++) begin
			build_frame(K_UNKNOWN, '0);
			run_frame("unknown");
			build_frame(K_LOOP, '0);
			run_frame("after unknown");
		end
		for (int i = 0; i < 25; i++) begin
			build_frame($urandom_range(0, 3), $urandom_range(0, 8));
			run_frame("random mix");
		end

		repeat (4) @(negedge clk);
		if (exp_q.size() == 0 && UUT.props.violations == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			abort_run("reply words or assertion failures left at end of test");
		end
	end

endmodule

/* files.f */
+incdir+include
src/cmd_pkg.sv
src/tx_path_if.sv
src/cmd_frame_ctrl.sv
src/cmd_tx_builder.sv
src/cmd_reg_bank.sv
src/command_top.sv
dv/command_properties.sv
dv/command_tb.sv
